//--- hdl/mipsExPkg.sv
/*
 * shared definitions for the MIPS execute stage
 * word and register address widths, opcode, funct and ALU codes,
 * forward selects and the two views of an instruction word
 */

package mipsExPkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // data path word
    localparam int dataWidth = 32;
    // 32 registers
    localparam int regAddrWidth = 5;

    ////////////////////////////////////////////////////////////
    // opcode field values
    ////////////////////////////////////////////////////////////

    // all R-format share opcode 0, funct selects the operation
    localparam logic [5:0] opRType = 6'd0;
    // branch on equal
    localparam logic [5:0] opBeq = 6'd4;
    // branch on not equal
    localparam logic [5:0] opBne = 6'd5;
    // load word
    localparam logic [5:0] opLw = 6'd35;
    // store word
    localparam logic [5:0] opSw = 6'd43;

    // funct field values, R-format only
    localparam logic [5:0] fnAdd = 6'd32;
    localparam logic [5:0] fnSub = 6'd34;
    localparam logic [5:0] fnAnd = 6'd36;
    localparam logic [5:0] fnOr = 6'd37;
    // set on less than, unsigned compare
    localparam logic [5:0] fnSlt = 6'd42;

    ////////////////////////////////////////////////////////////
    // ALU control codes
    ////////////////////////////////////////////////////////////

    localparam logic [3:0] aluAnd = 4'd0;
    localparam logic [3:0] aluOr = 4'd1;
    localparam logic [3:0] aluAdd = 4'd2;
    localparam logic [3:0] aluSub = 4'd6;
    localparam logic [3:0] aluSlt = 4'd7;
    // nor exists in the ALU, decode never selects it
    localparam logic [3:0] aluNor = 4'd12;

    // operand forward selects
    // register file data
    localparam logic [1:0] fwdReg = 2'd0;
    // result two stages ahead
    localparam logic [1:0] fwdWb = 2'd1;
    // result one stage ahead, wins over WB
    localparam logic [1:0] fwdMem = 2'd2;

    ////////////////////////////////////////////////////////////
    // instruction word
    ////////////////////////////////////////////////////////////

    // same 32 bits, read as R-format or as I-format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rView;
        struct packed {
            logic [5:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            // sign extended in decode
            logic [15:0] immediate;
        } iView;
    } instrWord;

endpackage

//--- hdl/operandForward.sv
/*
 * operandForward: forwarding unit and operand multiplexers
 * for both source registers, MEM ahead of WB, r0 never forwarded
 */

`timescale 1ns/1ps

module operandForward (
    input  logic [mipsExPkg::regAddrWidth-1:0] rs,
    input  logic [mipsExPkg::regAddrWidth-1:0] rt,
    input  logic [mipsExPkg::dataWidth-1:0]    regDataA,
    input  logic [mipsExPkg::dataWidth-1:0]    regDataB,
    input  logic [mipsExPkg::regAddrWidth-1:0] memRd,
    input  logic [mipsExPkg::regAddrWidth-1:0] wbRd,
    input  logic                               memRegWrite,
    input  logic                               wbRegWrite,
    input  logic [mipsExPkg::dataWidth-1:0]    memResult,
    input  logic [mipsExPkg::dataWidth-1:0]    wbResult,
    output logic [mipsExPkg::dataWidth-1:0]    operandA,
    output logic [mipsExPkg::dataWidth-1:0]    operandB
);

    import mipsExPkg::*;

    ////////////////////////////////////////////////////////////
    // forward select
    ////////////////////////////////////////////////////////////

    // one rule for both sources
    function automatic logic [1:0] pickSource(
        input logic [regAddrWidth-1:0] src,
        input logic [regAddrWidth-1:0] memDest,
        input logic                    memWrites,
        input logic [regAddrWidth-1:0] wbDest,
        input logic                    wbWrites
    );
        logic [1:0] sel;
        // newest producer first
        if (memWrites && (memDest != '0) && (memDest == src)) begin
            sel = fwdMem;
        end else if (wbWrites && (wbDest != '0) && (wbDest == src)) begin
            sel = fwdWb;
        end else begin
            // nobody in flight writes src
            sel = fwdReg;
        end
        return sel;
    endfunction

    logic [1:0] forwardA;
    logic [1:0] forwardB;

    assign forwardA = pickSource(rs, memRd, memRegWrite, wbRd, wbRegWrite);
    assign forwardB = pickSource(rt, memRd, memRegWrite, wbRd, wbRegWrite);

    ////////////////////////////////////////////////////////////
    // operand multiplexers
    ////////////////////////////////////////////////////////////

    // fwdReg and the unused code both fall to register data
    always_comb begin
        case (forwardA)
            fwdMem:  operandA = memResult;
            fwdWb:   operandA = wbResult;
            default: operandA = regDataA;
        endcase
    end

    // operandB doubles as store data for sw
    always_comb begin
        case (forwardB)
            fwdMem:  operandB = memResult;
            fwdWb:   operandB = wbResult;
            default: operandB = regDataB;
        endcase
    end

endmodule

//--- hdl/opDecode.sv
/*
 * opDecode: two level instruction decode
 * opcode gives stage controls, funct refines the ALU code for R-format,
 * plus destination register select and immediate sign extension
 */

`timescale 1ns/1ps

module opDecode (
    input  mipsExPkg::instrWord                instruction,
    output logic [3:0]                         aluCtrl,
    output logic                               useImm,
    output logic                               regWrite,
    output logic                               memRead,
    output logic                               memWrite,
    output logic                               isBeq,
    output logic                               isBne,
    output logic [mipsExPkg::dataWidth-1:0]    immValue,
    output logic [mipsExPkg::regAddrWidth-1:0] writeReg
);

    import mipsExPkg::*;

    // opcode level results
    logic       isRType;
    logic [3:0] baseAluCtrl;
    logic       baseRegWrite;

    // funct level results
    logic [3:0] functAluCtrl;
    logic       functKnown;

    ////////////////////////////////////////////////////////////
    // level one, opcode
    ////////////////////////////////////////////////////////////

    always_comb begin
        // unknown opcode ends up here, no controls, plain add
        isRType      = 1'b0;
        baseAluCtrl  = aluAdd;
        baseRegWrite = 1'b0;
        useImm       = 1'b0;
        memRead      = 1'b0;
        memWrite     = 1'b0;
        isBeq        = 1'b0;
        isBne        = 1'b0;
        case (instruction.rView.opcode)
            opRType: begin
                // operation comes from funct below
                isRType      = 1'b1;
                baseRegWrite = 1'b1;
            end
            opBeq: begin
                // compare by subtraction
                baseAluCtrl = aluSub;
                isBeq       = 1'b1;
            end
            opBne: begin
                baseAluCtrl = aluSub;
                isBne       = 1'b1;
            end
            opLw: begin
                // address = base + offset
                useImm       = 1'b1;
                memRead      = 1'b1;
                baseRegWrite = 1'b1;
            end
            opSw: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            default: begin
                baseAluCtrl = aluAdd;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // level two, funct
    ////////////////////////////////////////////////////////////

    always_comb begin
        functKnown = 1'b1;
        case (instruction.rView.funct)
            fnAdd:   functAluCtrl = aluAdd;
            fnSub:   functAluCtrl = aluSub;
            fnAnd:   functAluCtrl = aluAnd;
            fnOr:    functAluCtrl = aluOr;
            fnSlt:   functAluCtrl = aluSlt;
            default: begin
                // illegal funct, treated like illegal opcode
                functAluCtrl = aluAdd;
                functKnown   = 1'b0;
            end
        endcase
    end

    // funct only matters for R-format
    assign aluCtrl  = isRType ? functAluCtrl : baseAluCtrl;
    assign regWrite = baseRegWrite & (~isRType | functKnown);

    // rd for R-format, rt otherwise (lw)
    assign writeReg = isRType ? instruction.rView.rd : instruction.iView.rt;

    // 16 bit offset to full word
    assign immValue = {{(dataWidth - 16){instruction.iView.immediate[15]}},
                       instruction.iView.immediate};

endmodule

//--- hdl/aluExecute.sv
/*
 * aluExecute: second operand select, ALU, branch resolution
 * and the EX/MEM boundary register
 */

`timescale 1ns/1ps

module aluExecute (
    input  logic                               clock,
    input  logic                               WriteEnable,
    input  logic                               inValid,
    input  logic [mipsExPkg::dataWidth-1:0]    operandA,
    input  logic [mipsExPkg::dataWidth-1:0]    operandB,
    input  logic [3:0]                         aluCtrl,
    input  logic                               useImm,
    input  logic [mipsExPkg::dataWidth-1:0]    immValue,
    input  logic [mipsExPkg::regAddrWidth-1:0] writeReg,
    input  logic                               regWrite,
    input  logic                               memRead,
    input  logic                               memWrite,
    input  logic                               isBeq,
    input  logic                               isBne,
    output logic [mipsExPkg::dataWidth-1:0]    aluResult,
    output logic [mipsExPkg::dataWidth-1:0]    storeData,
    output logic [mipsExPkg::regAddrWidth-1:0] regWriteAddress,
    output logic                               resultValid,
    output logic                               regWriteOut,
    output logic                               memReadOut,
    output logic                               memWriteOut,
    output logic                               branchTaken
);

    import mipsExPkg::*;

    logic [dataWidth-1:0] aluInB;
    logic [dataWidth-1:0] aluOut;
    logic                 aluZero;
    logic                 takeBranch;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    // immediate for lw and sw, register otherwise
    assign aluInB = useImm ? immValue : operandB;

    always_comb begin
        case (aluCtrl)
            aluAnd: aluOut = operandA & aluInB;
            aluOr:  aluOut = operandA | aluInB;
            aluAdd: aluOut = operandA + aluInB;
            aluSub: aluOut = operandA - aluInB;
            // unsigned compare, result is 0 or 1
            aluSlt: aluOut = {{(dataWidth - 1){1'b0}}, (operandA < aluInB)};
            aluNor: aluOut = ~(operandA | aluInB);
            // codes decode never produces
            default: aluOut = '0;
        endcase
    end

    assign aluZero = (aluOut == '0);

    // beq on equal operands, bne on unequal
    assign takeBranch = (isBeq & aluZero) | (isBne & ~aluZero);

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////

    // control bits, cleared by reset and by an empty slot
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            resultValid <= 1'b0;
            regWriteOut <= 1'b0;
            memReadOut  <= 1'b0;
            memWriteOut <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            resultValid <= inValid;
            regWriteOut <= inValid & regWrite;
            memReadOut  <= inValid & memRead;
            memWriteOut <= inValid & memWrite;
            branchTaken <= inValid & takeBranch;
        end
    end

    // payload, held while no instruction arrives
    always_ff @(posedge clock) begin
        if (inValid) begin
            aluResult       <= aluOut;
            storeData       <= operandB;
            regWriteAddress <= writeReg;
        end
    end

endmodule

//--- hdl/exStage.sv
/*
 * exStage: execute stage top level
 * forwarding and decode side by side, feeding the ALU stage
 */

`timescale 1ns/1ps

module exStage (
    input  logic                               clock,
    input  logic                               WriteEnable,
    input  logic                               inValid,
    input  mipsExPkg::instrWord                instruction,
    input  logic [mipsExPkg::dataWidth-1:0]    regDataA,
    input  logic [mipsExPkg::dataWidth-1:0]    regDataB,
    input  logic [mipsExPkg::dataWidth-1:0]    memResult,
    input  logic [mipsExPkg::regAddrWidth-1:0] memRd,
    input  logic                               memRegWrite,
    input  logic [mipsExPkg::dataWidth-1:0]    wbResult,
    input  logic [mipsExPkg::regAddrWidth-1:0] wbRd,
    input  logic                               wbRegWrite,
    output logic [mipsExPkg::dataWidth-1:0]    aluResult,
    output logic [mipsExPkg::dataWidth-1:0]    storeData,
    output logic [mipsExPkg::regAddrWidth-1:0] regWriteAddress,
    output logic                               resultValid,
    output logic                               regWriteOut,
    output logic                               memReadOut,
    output logic                               memWriteOut,
    output logic                               branchTaken
);

    import mipsExPkg::*;

    // forwarded operands
    logic [dataWidth-1:0]    operandA;
    logic [dataWidth-1:0]    operandB;

    // decode outputs
    logic [3:0]              aluCtrl;
    logic                    useImm;
    logic [dataWidth-1:0]    immValue;
    logic [regAddrWidth-1:0] writeReg;
    logic                    regWrite;
    logic                    memRead;
    logic                    memWrite;
    logic                    isBeq;
    logic                    isBne;

    ////////////////////////////////////////////////////////////
    // combinational front, no added latency
    ////////////////////////////////////////////////////////////

    operandForward u_forward (
        .rs          (instruction.rView.rs),
        .rt          (instruction.rView.rt),
        .regDataA    (regDataA),
        .regDataB    (regDataB),
        .memRd       (memRd),
        .wbRd        (wbRd),
        .memRegWrite (memRegWrite),
        .wbRegWrite  (wbRegWrite),
        .memResult   (memResult),
        .wbResult    (wbResult),
        .operandA    (operandA),
        .operandB    (operandB)
    );

    opDecode u_decode (
        .instruction (instruction),
        .aluCtrl     (aluCtrl),
        .useImm      (useImm),
        .regWrite    (regWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .isBeq       (isBeq),
        .isBne       (isBne),
        .immValue    (immValue),
        .writeReg    (writeReg)
    );

    // ALU and the one register stage
    aluExecute u_execute (
        .clock           (clock),
        .WriteEnable     (WriteEnable),
        .inValid         (inValid),
        .operandA        (operandA),
        .operandB        (operandB),
        .aluCtrl         (aluCtrl),
        .useImm          (useImm),
        .immValue        (immValue),
        .writeReg        (writeReg),
        .regWrite        (regWrite),
        .memRead         (memRead),
        .memWrite        (memWrite),
        .isBeq           (isBeq),
        .isBne           (isBne),
        .aluResult       (aluResult),
        .storeData       (storeData),
        .regWriteAddress (regWriteAddress),
        .resultValid     (resultValid),
        .regWriteOut     (regWriteOut),
        .memReadOut      (memReadOut),
        .memWriteOut     (memWriteOut),
        .branchTaken     (branchTaken)
    );

endmodule

//--- sim/exStage_sva.sv
/*
 * exStageSva: concurrent checks on the EX/MEM control outputs
 * bound into every exStage instance
 */

`timescale 1ns/1ps

module exStageSva (
    input logic clock,
    input logic WriteEnable,
    input logic resultValid,
    input logic regWriteOut,
    input logic memReadOut,
    input logic memWriteOut,
    input logic branchTaken
);

    import mipsExPkg::*;

    logic anyControl;

    // any control bit raised
    assign anyControl = regWriteOut | memReadOut | memWriteOut | branchTaken;

    // reset clears the whole control word
    resetClears: assert property (@(posedge clock)
        WriteEnable |=> !(resultValid || anyControl))
        else $error("control outputs not low one cycle after reset");

    // a word is either loaded or stored
    noReadAndWrite: assert property (@(posedge clock) disable iff (WriteEnable)
        !(memReadOut && memWriteOut))
        else $error("memReadOut and memWriteOut high together");

    controlNeedsValid: assert property (@(posedge clock) disable iff (WriteEnable)
        anyControl |-> resultValid)
        else $error("control output high without resultValid");

    // branches write no register
    branchNoWrite: assert property (@(posedge clock) disable iff (WriteEnable)
        branchTaken |-> !regWriteOut)
        else $error("branchTaken together with regWriteOut");

endmodule

bind exStage exStageSva u_sva (
    .clock       (clock),
    .WriteEnable (WriteEnable),
    .resultValid (resultValid),
    .regWriteOut (regWriteOut),
    .memReadOut  (memReadOut),
    .memWriteOut (memWriteOut),
    .branchTaken (branchTaken)
);

//--- sim/exStageTb.sv
/*
 * testbench top with clock, reset and LFSR driven random instructions
 * reference model with a one cycle queue, compare task and watchdog
 */

`timescale 1ns/1ps

module exStageTb;

    import mipsExPkg::*;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 10;
    localparam int numTests = 3000;
    // test loop with reset, release and drain cycles plus slack
    localparam int watchdogNs = (resetCycles + numTests + 8) * clockPeriod + 100;

    logic clock = 1'b0;
    logic WriteEnable;
    logic inValid;
    instrWord instruction;
    logic [dataWidth-1:0] regDataA, regDataB, memResult, wbResult;
    logic [regAddrWidth-1:0] memRd, wbRd;
    logic memRegWrite, wbRegWrite;
    logic [dataWidth-1:0] aluResult, storeData;
    logic [regAddrWidth-1:0] regWriteAddress;
    logic resultValid, regWriteOut, memReadOut, memWriteOut, branchTaken;

    // next stimulus is built here before it is driven
    logic stValid;
    instrWord stInstr;
    logic [dataWidth-1:0] stRegA, stRegB, stMemResult, stWbResult;
    logic [regAddrWidth-1:0] stMemRd, stWbRd;
    logic stMemWrite, stWbWrite;

    // model state for data outputs that hold while idle
    logic haveData;
    logic [dataWidth-1:0] lastAlu, lastStore;
    logic [regAddrWidth-1:0] lastAddr;
    // {haveData, valid, regW, memR, memW, branch, addr, alu, store}
    logic [74:0] expQ[$];
    string nameQ[$];

    logic [15:0] lfsrState;
    int errorCount;
    int cntFwdMem, cntFwdWb, cntTaken, cntIllegal;

    always #(clockPeriod / 2) clock = ~clock;

    exStage u_dut (.*);

    ////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic [31:0] lfsrBits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // small values now and then so compares hit equal
    function automatic logic [31:0] dataWord();
        logic [31:0] value;
        if (lfsrBits(2) == 0) begin
            value = lfsrBits(2);
        end else begin
            value = lfsrBits(32);
        end
        return value;
    endfunction

    task automatic makeStimulus();
        logic [5:0] op;
        logic [5:0] fn;
        stValid = (lfsrBits(2) != 0);
        case (lfsrBits(3))
            0, 1, 2: op = opRType;
            3: op = opBeq;
            4: op = opBne;
            5: op = opLw;
            6: op = opSw;
            // mostly illegal opcodes
            default: op = 6'(lfsrBits(6));
        endcase
        case (lfsrBits(3))
            0: fn = fnAdd;
            1: fn = fnSub;
            2: fn = fnAnd;
            3: fn = fnOr;
            4: fn = fnSlt;
            default: fn = 6'(lfsrBits(6));
        endcase
        // registers 0..3 only so collisions are frequent
        if (op == opRType) begin
            stInstr.rView.opcode = op;
            stInstr.rView.rs = 5'(lfsrBits(2));
            stInstr.rView.rt = 5'(lfsrBits(2));
            stInstr.rView.rd = 5'(lfsrBits(2));
            stInstr.rView.shamt = 5'(lfsrBits(5));
            stInstr.rView.funct = fn;
        end else begin
            stInstr.iView.opcode = op;
            stInstr.iView.rs = 5'(lfsrBits(2));
            stInstr.iView.rt = 5'(lfsrBits(2));
            stInstr.iView.immediate = 16'(lfsrBits(16));
        end
        stRegA = dataWord();
        stRegB = dataWord();
        stMemResult = dataWord();
        stWbResult = dataWord();
        stMemRd = 5'(lfsrBits(2));
        stWbRd = 5'(lfsrBits(2));
        stMemWrite = (lfsrBits(2) != 0);
        stWbWrite = (lfsrBits(2) != 0);
    endtask

    task automatic driveInputs();
        inValid <= stValid;
        instruction <= stInstr;
        regDataA <= stRegA;
        regDataB <= stRegB;
        memResult <= stMemResult;
        memRd <= stMemRd;
        memRegWrite <= stMemWrite;
        wbResult <= stWbResult;
        wbRd <= stWbRd;
        wbRegWrite <= stWbWrite;
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // newest writer wins and r0 or idle writers never forward
    function automatic logic [1:0] forwardSource(input logic [regAddrWidth-1:0] src);
        if (stMemWrite && stMemRd != 0 && stMemRd == src) return fwdMem;
        if (stWbWrite && stWbRd != 0 && stWbRd == src) return fwdWb;
        return fwdReg;
    endfunction

    function automatic logic [31:0] forwardedValue(input logic [1:0] sel,
                                                    input logic [31:0] regValue);
        if (sel == fwdMem) return stMemResult;
        if (sel == fwdWb) return stWbResult;
        return regValue;
    endfunction

    task automatic predictOutputs();
        logic [1:0] selA, selB;
        logic [31:0] a, b, imm, res;
        logic regW, memR, memW, br;
        logic [4:0] addr;
        string kind;
        selA = forwardSource(stInstr.rView.rs);
        selB = forwardSource(stInstr.rView.rt);
        a = forwardedValue(selA, stRegA);
        b = forwardedValue(selB, stRegB);
        imm = {{16{stInstr.iView.immediate[15]}}, stInstr.iView.immediate};
        // unknown codes give no controls and add the two operands
        regW = 0;
        memR = 0;
        memW = 0;
        br = 0;
        res = a + b;
        addr = stInstr.iView.rt;
        kind = "illegal opcode";
        case (stInstr.rView.opcode)
            opRType: begin
                addr = stInstr.rView.rd;
                regW = 1;
                case (stInstr.rView.funct)
                    fnAdd: kind = "R add";
                    fnSub: begin
                        kind = "R sub";
                        res = a - b;
                    end
                    fnAnd: begin
                        kind = "R and";
                        res = a & b;
                    end
                    fnOr: begin
                        kind = "R or";
                        res = a | b;
                    end
                    fnSlt: begin
                        kind = "R slt";
                        res = (a < b) ? 32'd1 : 32'd0;
                    end
                    default: begin
                        kind = "illegal funct";
                        regW = 0;
                    end
                endcase
            end
            opBeq: begin
                kind = "beq";
                res = a - b;
                br = (a == b);
            end
            opBne: begin
                kind = "bne";
                res = a - b;
                br = (a != b);
            end
            opLw: begin
                kind = "lw";
                res = a + imm;
                memR = 1;
                regW = 1;
            end
            opSw: begin
                kind = "sw";
                res = a + imm;
                memW = 1;
            end
            default: ;
        endcase
        if (stValid) begin
            haveData = 1;
            lastAlu = res;
            lastStore = b;
            lastAddr = addr;
            if (selA == fwdMem || selB == fwdMem) kind = {kind, " fwd mem"};
            if (selA == fwdWb || selB == fwdWb) kind = {kind, " fwd wb"};
            cntFwdMem += (selA == fwdMem || selB == fwdMem);
            cntFwdWb += (selA == fwdWb || selB == fwdWb);
            cntTaken += br;
            cntIllegal += (kind.substr(0, 6) == "illegal");
        end else begin
            kind = "idle";
        end
        expQ.push_back({haveData, stValid, stValid & regW, stValid & memR, stValid & memW,
                        stValid & br, lastAddr, lastAlu, lastStore});
        nameQ.push_back(kind);
    endtask

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s expected %0h actual %0h", testName, expected, actual);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic checkIdleControls(input string testName);
        checkValue({testName, " resultValid"}, 0, resultValid);
        checkValue({testName, " regWriteOut"}, 0, regWriteOut);
        checkValue({testName, " memReadOut"}, 0, memReadOut);
        checkValue({testName, " memWriteOut"}, 0, memWriteOut);
        checkValue({testName, " branchTaken"}, 0, branchTaken);
    endtask

    task automatic compareOutputs();
        logic [74:0] exp;
        string name;
        exp = expQ.pop_front();
        name = nameQ.pop_front();
        checkValue({name, " resultValid"}, exp[73], resultValid);
        checkValue({name, " regWriteOut"}, exp[72], regWriteOut);
        checkValue({name, " memReadOut"}, exp[71], memReadOut);
        checkValue({name, " memWriteOut"}, exp[70], memWriteOut);
        checkValue({name, " branchTaken"}, exp[69], branchTaken);
        // payload is undefined until the first valid word
        if (exp[74]) begin
            checkValue({name, " regWriteAddress"}, exp[68:64], regWriteAddress);
            checkValue({name, " aluResult"}, exp[63:32], aluResult);
            checkValue({name, " storeData"}, exp[31:0], storeData);
        end
    endtask

    initial begin
        #(watchdogNs);
        $display("watchdog expired after %0d ns, the test loop never finished", watchdogNs);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        lfsrState = 16'd15;
        errorCount = 0;
        cntFwdMem = 0;
        cntFwdWb = 0;
        cntTaken = 0;
        cntIllegal = 0;
        haveData = 0;
        lastAlu = '0;
        lastStore = '0;
        lastAddr = '0;
        stValid = 0;
        stInstr = '0;
        stRegA = '0;
        stRegB = '0;
        stMemResult = '0;
        stWbResult = '0;
        stMemRd = '0;
        stWbRd = '0;
        stMemWrite = 0;
        stWbWrite = 0;
        WriteEnable = 1'b1;
        inValid = 1'b0;
        instruction = '0;
        regDataA = '0;
        regDataB = '0;
        memResult = '0;
        memRd = '0;
        memRegWrite = 1'b0;
        wbResult = '0;
        wbRd = '0;
        wbRegWrite = 1'b0;
        repeat (resetCycles) begin
            @(posedge clock);
            @(negedge clock);
            checkIdleControls("reset");
        end
        // release reset and expect the idle inputs one edge later
        @(posedge clock);
        WriteEnable <= 1'b0;
        predictOutputs();
        // outputs checked half a cycle after each capture edge
        for (int n = 0; n < numTests; n++) begin
            @(posedge clock);
            makeStimulus();
            driveInputs();
            predictOutputs();
            @(negedge clock);
            compareOutputs();
        end
        // drain the last instruction with an idle slot
        @(posedge clock);
        stValid = 0;
        driveInputs();
        predictOutputs();
        @(negedge clock);
        compareOutputs();
        if (cntFwdMem == 0 || cntFwdWb == 0 || cntTaken == 0 || cntIllegal == 0) begin
            $display("stimulus missed a forwarding case, a taken branch or an illegal code");
            errorCount++;
        end
        if (errorCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

//--- verilog.f
hdl/mipsExPkg.sv
hdl/operandForward.sv
hdl/opDecode.sv
hdl/aluExecute.sv
hdl/exStage.sv
sim/exStage_sva.sv
sim/exStageTb.sv

//--- Bender.yml
package:
  name: mips_ex_stage

sources:
  # design, package first
  - files:
      - hdl/mipsExPkg.sv
      - hdl/operandForward.sv
      - hdl/opDecode.sv
      - hdl/aluExecute.sv
      - hdl/exStage.sv

  # assertions and testbench
  - target: test
    files:
      - sim/exStage_sva.sv
      - sim/exStageTb.sv
